/* include/card_defs.svh */
`ifndef CARD_DEFS_SVH
`define CARD_DEFS_SVH

//////////////////////////////
// Active raster in pixels
`define H_ACTIVE 640
`define V_ACTIVE 480

//////////////////////////////
// Card grid, 4x4 slots
`define GRID_X0 121
`define GRID_Y0 60
`define CARD_PITCH 100
`define CARD_W 100
`define CARD_H 100

// Colour of a face-down card, RRR_GGG_BBB
`define CARD_BACK_RGB 9'b001_001_110

// Rendered pixel buffer
`define PIX_FIFO_DEPTH 8

`endif

/* hdl/card_pkg.sv */
package card_pkg;

	// Board commands
	typedef enum logic [1:0] {
		OP_FACE_UP,
		OP_FACE_DOWN,
		OP_REMOVE,
		OP_RESET_BOARD
	} card_op_t;

	// Per-slot card state
	typedef enum logic [1:0] {
		SLOT_DOWN,
		SLOT_UP,
		SLOT_GONE
	} slot_state_t;

	typedef enum logic {
		SCAN_IDLE,
		SCAN_RUN
	} scan_state_t;

	typedef struct packed {
		card_op_t    op;
		logic [3:0]  slot;
	} card_cmd_t;

	// Slot 0 is top left, row-major
	typedef slot_state_t [15:0] board_t;

	typedef struct packed {
		logic [9:0]  x;
		logic [9:0]  y;
		logic        sof;
		logic        eof;
	} pix_req_t;

	typedef struct packed {
		logic [8:0]  rgb;
		logic        card_on;
		logic        sof;
		logic        eof;
	} pixel_t;

endpackage

/* hdl/card_rom.sv */
`timescale 1ns/1ps
`include "card_defs.svh"

module card_rom (
	input  logic        clk,
	input  logic        en,
	input  logic [13:0] addr,
	output logic [8:0]  data
);

	logic [8:0] mem [0:`CARD_W * `CARD_H - 1];

	// Coarse 16-pixel blocks in the upper bits, fine XOR pattern below
	function automatic logic [8:0] face_pixel(input int r, input int c);
		logic [9:0] rb;
		logic [9:0] cb;
		logic [9:0] mix;
		rb  = 10'(r / 16);
		cb  = 10'(c / 16);
		mix = 10'(r ^ c);
		return {rb[2:0], cb[2:0], mix[2:0]};
	endfunction

	initial begin
		for (int r = 0; r < `CARD_H; r++) begin
			for (int c = 0; c < `CARD_W; c++) begin
				mem[r * `CARD_W + c] = face_pixel(r, c);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (en) data <= mem[addr];
	end

endmodule

/* hdl/pixel_scan.sv */
`timescale 1ns/1ps
`include "card_defs.svh"

module pixel_scan import card_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  card_cmd_t   cmd,
	input  logic        cmd_valid,
	input  logic        frame_start,
	input  logic        req_ready,
	output logic        cmd_ready,
	output board_t      board,
	output pix_req_t    req,
	output logic        req_valid,
	output logic        scan_busy
);

	scan_state_t state;
	logic [9:0]  x;
	logic [9:0]  y;
	logic        last_x;
	logic        last_y;

	assign last_x = (x == 10'(`H_ACTIVE - 1));
	assign last_y = (y == 10'(`V_ACTIVE - 1));

	assign cmd_ready = (state == SCAN_IDLE);
	assign scan_busy = (state == SCAN_RUN);
	assign req_valid = scan_busy;

	always_comb begin
		req.x   = x;
		req.y   = y;
		req.sof = (x == '0) && (y == '0);
		req.eof = last_x && last_y;
	end

	//////////////////////////////
	// Raster walk, x fastest
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SCAN_IDLE;
			x     <= '0;
			y     <= '0;
		end else begin
			case (state)
				SCAN_IDLE: if (frame_start) state <= SCAN_RUN;
				SCAN_RUN: begin
					if (req_ready) begin
						// Counters wrap to 0,0 on the eof request
						if (last_x) begin
							x <= '0;
							y <= last_y ? '0 : y + 10'd1;
						end else begin
							x <= x + 10'd1;
						end
						if (req.eof) state <= SCAN_IDLE;
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Board state, written only while idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) board[i] <= SLOT_DOWN;
		end else if (cmd_valid && cmd_ready) begin
			case (cmd.op)
				OP_FACE_UP:     board[cmd.slot] <= SLOT_UP;
				OP_FACE_DOWN:   board[cmd.slot] <= SLOT_DOWN;
				OP_REMOVE:      board[cmd.slot] <= SLOT_GONE;
				OP_RESET_BOARD: for (int i = 0; i < 16; i++) board[i] <= SLOT_DOWN;
				default:        ;
			endcase
		end
	end

endmodule

/* hdl/card_render.sv */
`timescale 1ns/1ps
`include "card_defs.svh"

module card_render import card_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  board_t    board,
	input  pix_req_t  req,
	input  logic      req_valid,
	input  logic      pix_ready,
	output logic      req_ready,
	output pixel_t    pix,
	output logic      pix_valid
);

	localparam int GRID_N = 4;

	// Splits a grid offset into {column index, local offset}
	function automatic logic [8:0] grid_split(input logic [9:0] off);
		logic [1:0] idx;
		logic [9:0] loc;
		idx = 2'd0;
		loc = off;
		for (int i = GRID_N - 1; i > 0; i--) begin
			if (idx == 2'd0 && off >= 10'(i * `CARD_PITCH)) begin
				idx = 2'(i);
				loc = off - 10'(i * `CARD_PITCH);
			end
		end
		return {idx, loc[6:0]};
	endfunction

	logic [8:0]  x_split;
	logic [8:0]  y_split;
	logic        x_in;
	logic        y_in;
	logic        hit;
	logic [3:0]  slot;
	logic [13:0] addr;

	logic        s1_valid, s1_hit, s1_sof, s1_eof;
	logic [3:0]  s1_slot;
	logic [13:0] s1_addr;
	logic        s2_valid, s2_hit, s2_sof, s2_eof;
	slot_state_t s2_state;
	logic        s1_adv, s2_adv;
	logic        rom_en;
	logic [8:0]  rom_data;

	//////////////////////////////
	// Stage 1 decode
	assign x_in = (req.x >= 10'(`GRID_X0)) && (req.x < 10'(`GRID_X0 + GRID_N * `CARD_PITCH));
	assign y_in = (req.y >= 10'(`GRID_Y0)) && (req.y < 10'(`GRID_Y0 + GRID_N * `CARD_PITCH));
	assign x_split = grid_split(req.x - 10'(`GRID_X0));
	assign y_split = grid_split(req.y - 10'(`GRID_Y0));
	assign hit  = x_in && y_in && (x_split[6:0] < 7'(`CARD_W)) && (y_split[6:0] < 7'(`CARD_H));
	assign slot = {y_split[8:7], x_split[8:7]};
	assign addr = 14'(y_split[6:0]) * 14'(`CARD_W) + 14'(x_split[6:0]);

	// An empty stage can always load
	assign s2_adv    = !s2_valid || pix_ready;
	assign s1_adv    = !s1_valid || s2_adv;
	assign req_ready = s1_adv;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_adv) s1_valid <= req_valid;
			if (s2_adv) s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_adv) begin
			s1_hit  <= hit;
			s1_slot <= slot;
			s1_addr <= addr;
			s1_sof  <= req.sof;
			s1_eof  <= req.eof;
		end
		if (s2_adv && s1_valid) begin
			s2_hit   <= s1_hit;
			s2_state <= board[s1_slot];
			s2_sof   <= s1_sof;
			s2_eof   <= s1_eof;
		end
	end

	// Face data lands together with stage 2
	assign rom_en = s2_adv && s1_valid && s1_hit;

	card_rom i_card_rom (
		.clk  (clk),
		.en   (rom_en),
		.addr (s1_addr),
		.data (rom_data)
	);

	//////////////////////////////
	// Stage 2 colour select
	always_comb begin
		pix.sof     = s2_sof;
		pix.eof     = s2_eof;
		pix.rgb     = '0;
		pix.card_on = 1'b0;
		if (s2_hit) begin
			case (s2_state)
				SLOT_UP: begin
					pix.rgb     = rom_data;
					pix.card_on = 1'b1;
				end
				SLOT_DOWN: begin
					pix.rgb     = `CARD_BACK_RGB;
					pix.card_on = 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign pix_valid = s2_valid;

endmodule

/* hdl/pixel_fifo.sv */
`timescale 1ns/1ps
`include "card_defs.svh"

module pixel_fifo import card_pkg::*; #(
	parameter int DEPTH = `PIX_FIFO_DEPTH
) (
	input  logic    clk,
	input  logic    rst_n,
	input  pixel_t  in,
	input  logic    in_valid,
	input  logic    out_ready,
	output logic    in_ready,
	output pixel_t  out,
	output logic    out_valid
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	pixel_t          mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;
	logic            push;
	logic            pop;

	// Wrap explicitly so DEPTH need not be a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready  = (count != CW'(DEPTH));
	assign out_valid = (count != '0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out       = mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= next_ptr(wr_ptr);
			if (pop) rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= in;
	end

endmodule

/* hdl/pixel_out.sv */
`timescale 1ns/1ps

module pixel_out import card_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  pixel_t      in,
	input  logic        in_valid,
	input  logic        pix_ready,
	output logic        in_ready,
	output pixel_t      pix,
	output logic        pix_valid,
	output logic [7:0]  frame_count
);

	logic delivered;

	// Load when empty or when the sink takes the current pixel
	assign in_ready  = !pix_valid || pix_ready;
	assign delivered = pix_valid && pix_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
		end else if (in_ready) begin
			pix_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready && in_valid) pix <= in;
	end

	//////////////////////////////
	// Frames handed to the sink, wraps at 256
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_count <= '0;
		end else if (delivered && pix.eof) begin
			frame_count <= frame_count + 8'd1;
		end
	end

endmodule

/* hdl/card_display_top.sv */
`timescale 1ns/1ps
`include "card_defs.svh"

module card_display_top import card_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  card_cmd_t   cmd,
	input  logic        cmd_valid,
	input  logic        frame_start,
	input  logic        pix_ready,
	output logic        cmd_ready,
	output logic        scan_busy,
	output pixel_t      pix,
	output logic        pix_valid,
	output logic [7:0]  frame_count
);

	board_t   board;
	pix_req_t req;
	logic     req_valid;
	logic     req_ready;
	pixel_t   rnd_pix;
	logic     rnd_valid;
	logic     rnd_ready;
	pixel_t   fifo_pix;
	logic     fifo_valid;
	logic     fifo_ready;

	//////////////////////////////
	// Scan, render, buffer, output
	pixel_scan i_pixel_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.frame_start (frame_start),
		.req_ready   (req_ready),
		.cmd_ready   (cmd_ready),
		.board       (board),
		.req         (req),
		.req_valid   (req_valid),
		.scan_busy   (scan_busy)
	);

	card_render i_card_render (
		.clk       (clk),
		.rst_n     (rst_n),
		.board     (board),
		.req       (req),
		.req_valid (req_valid),
		.pix_ready (rnd_ready),
		.req_ready (req_ready),
		.pix       (rnd_pix),
		.pix_valid (rnd_valid)
	);

	pixel_fifo #(.DEPTH(`PIX_FIFO_DEPTH)) i_pixel_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in        (rnd_pix),
		.in_valid  (rnd_valid),
		.out_ready (fifo_ready),
		.in_ready  (rnd_ready),
		.out       (fifo_pix),
		.out_valid (fifo_valid)
	);

	pixel_out i_pixel_out (
		.clk         (clk),
		.rst_n       (rst_n),
		.in          (fifo_pix),
		.in_valid    (fifo_valid),
		.pix_ready   (pix_ready),
		.in_ready    (fifo_ready),
		.pix         (pix),
		.pix_valid   (pix_valid),
		.frame_count (frame_count)
	);

endmodule

/* sim/card_display_sva.sv */
`timescale 1ns/1ps

module card_display_sva import card_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  board_t  board,
	input  pixel_t  pix,
	input  logic    pix_valid,
	input  logic    pix_ready,
	input  logic    scan_busy
);

	// Assertion failures so far
	int fail_count = 0;

	// Output stays quiet during reset
	a_no_valid_in_reset: assert property (@(posedge clk) !rst_n |-> !pix_valid)
		else begin
			fail_count++;
			$error("pix_valid high while rst_n is low");
		end

	// A stalled pixel must not change
	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix))
		else begin
			fail_count++;
			$error("pix changed or dropped while the sink stalled");
		end

	// Commands cannot touch the board during a scan
	a_board_frozen_in_scan: assert property (@(posedge clk) disable iff (!rst_n)
		scan_busy |=> $stable(board))
		else begin
			fail_count++;
			$error("board changed during a frame scan");
		end

endmodule

bind card_display_top card_display_sva i_card_display_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.board     (board),
	.pix       (pix),
	.pix_valid (pix_valid),
	.pix_ready (pix_ready),
	.scan_busy (scan_busy)
);

/* sim/tb_card_display.sv */
`timescale 1ns/1ps
`include "card_defs.svh"

module tb_card_display import card_pkg::*; ();

	localparam int FRAMES          = 3;
	localparam int RESET_CYCLES    = 10;
	localparam int FRAME_PIX       = `H_ACTIVE * `V_ACTIVE;
	// Up to 8 commands with gaps of up to 3 cycles and the start pulse
	localparam int CMD_CYCLES      = 64;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + FRAMES * (4 * FRAME_PIX + CMD_CYCLES);
	// Render stages, FIFO entries and the output register
	localparam int MAX_IN_FLIGHT   = 2 + `PIX_FIFO_DEPTH + 1;

	logic        clk;
	logic        rst_n;
	card_cmd_t   cmd;
	logic        cmd_valid;
	logic        frame_start;
	logic        pix_ready;
	logic        cmd_ready;
	logic        scan_busy;
	pixel_t      pix;
	logic        pix_valid;
	logic [7:0]  frame_count;

	integer      seed = 82144;
	slot_state_t model_board [16];
	int          eofs_accepted;

	card_display_top i_card_display_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.frame_start (frame_start),
		.pix_ready   (pix_ready),
		.cmd_ready   (cmd_ready),
		.scan_busy   (scan_busy),
		.pix         (pix),
		.pix_valid   (pix_valid),
		.frame_count (frame_count)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_assertions();
		if (i_card_display_top.i_card_display_sva.fail_count != 0) begin
			fail_run("A bound assertion on the DUT failed");
		end
	endtask

	function automatic void apply_command(input card_cmd_t c);
		case (c.op)
			OP_FACE_UP:     model_board[c.slot] = SLOT_UP;
			OP_FACE_DOWN:   model_board[c.slot] = SLOT_DOWN;
			OP_REMOVE:      model_board[c.slot] = SLOT_GONE;
			default:        foreach (model_board[i]) model_board[i] = SLOT_DOWN;
		endcase
	endfunction

	//////////////////////////////
	// Reference pixel as {rgb, card_on}
	function automatic logic [9:0] model_pixel(input int x, input int y);
		int         dx;
		int         dy;
		int         rb;
		int         cb;
		int         mix;
		logic [3:0] slot;
		if (x < `GRID_X0 || x >= `GRID_X0 + 4 * `CARD_PITCH ||
				y < `GRID_Y0 || y >= `GRID_Y0 + 4 * `CARD_PITCH) begin
			return 10'd0;
		end
		dx   = x - `GRID_X0;
		dy   = y - `GRID_Y0;
		slot = 4'((dy / `CARD_PITCH) * 4 + dx / `CARD_PITCH);
		dx   = dx % `CARD_PITCH;
		dy   = dy % `CARD_PITCH;
		if (dx >= `CARD_W || dy >= `CARD_H) return 10'd0;
		// Face image from row block, column block and row XOR column
		rb  = dy / 16;
		cb  = dx / 16;
		mix = dy ^ dx;
		case (model_board[slot])
			SLOT_UP:   return {rb[2:0], cb[2:0], mix[2:0], 1'b1};
			SLOT_DOWN: return {9'(`CARD_BACK_RGB), 1'b1};
			default:   return 10'd0;
		endcase
	endfunction

	task automatic send_commands();
		integer    r;
		int        n;
		card_cmd_t c;
		r = $random(seed);
		n = 4 + int'(r[7:0]) % 5;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			cmd_valid = 1'b0;
			repeat (int'(r[1:0])) @(negedge clk);
			r = $random(seed);
			c.op      = card_op_t'(r[1:0]);
			c.slot    = r[5:2];
			cmd       = c;
			cmd_valid = 1'b1;
			check_value("cmd_ready", 32'(cmd_ready), 32'd1);
			apply_command(c);
			@(negedge clk);
		end
		cmd_valid = 1'b0;
		frame_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		check_value("scan_busy", 32'(scan_busy), 32'd1);
	endtask

	task automatic collect_frame();
		integer     r;
		int         count;
		logic       done;
		logic       busy_window;
		logic [9:0] exp;
		count = 0;
		done  = 1'b0;
		while (!done) begin
			check_assertions();
			check_value("frame_count", 32'(frame_count), 32'(eofs_accepted & 255));
			// The eof request cannot have left the scan yet
			busy_window = (count < FRAME_PIX - MAX_IN_FLIGHT);
			if (busy_window) begin
				check_value("cmd_ready", 32'(cmd_ready), 32'd0);
				check_value("scan_busy", 32'(scan_busy), 32'd1);
			end
			r = $random(seed);
			pix_ready = (r[1:0] != 2'b00);
			// Commands offered during the scan must be refused
			cmd       = card_cmd_t'(r[9:4]);
			cmd_valid = busy_window && r[2];
			if (pix_valid && pix_ready) begin
				exp = model_pixel(count % `H_ACTIVE, count / `H_ACTIVE);
				check_value("pix.rgb", 32'(pix.rgb), 32'(exp[9:1]));
				check_value("pix.card_on", 32'(pix.card_on), 32'(exp[0]));
				check_value("pix.sof", 32'(pix.sof), 32'(count == 0));
				check_value("pix.eof", 32'(pix.eof), 32'(count == FRAME_PIX - 1));
				count++;
				if (pix.eof) begin
					done = 1'b1;
					eofs_accepted++;
				end
			end
			@(negedge clk);
		end
		pix_ready = 1'b0;
		cmd_valid = 1'b0;
		check_value("frame pixel count", 32'(count), 32'(FRAME_PIX));
		check_value("frame_count", 32'(frame_count), 32'(eofs_accepted & 255));
		check_value("scan_busy", 32'(scan_busy), 32'd0);
	endtask

	//////////////////////////////
	// Main sequence
	initial begin
		rst_n         = 1'b0;
		cmd           = '0;
		cmd_valid     = 1'b0;
		frame_start   = 1'b0;
		pix_ready     = 1'b0;
		eofs_accepted = 0;
		foreach (model_board[i]) model_board[i] = SLOT_DOWN;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("cmd_ready", 32'(cmd_ready), 32'd1);
		check_value("pix_valid", 32'(pix_valid), 32'd0);
		check_value("scan_busy", 32'(scan_busy), 32'd0);
		check_value("frame_count", 32'(frame_count), 32'd0);
		for (int f = 0; f < FRAMES; f++) begin
			send_commands();
			collect_frame();
		end
		if (i_card_display_top.i_card_display_sva.fail_count != 0) begin
			fail_run("A bound assertion on the DUT failed");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_run("Timeout: the frames did not finish within the allowed number of cycles");
	end

endmodule

/* tb.f */
+incdir+include
hdl/card_pkg.sv
hdl/card_rom.sv
hdl/pixel_scan.sv
hdl/card_render.sv
hdl/pixel_fifo.sv
hdl/pixel_out.sv
hdl/card_display_top.sv
sim/card_display_sva.sv
sim/tb_card_display.sv

/* Makefile */
# Verilator build and run for the card display testbench

VERILATOR ?= verilator
TOP       ?= tb_card_display
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
